//--- hw/xv_pkg.sv
// shared video controller definitions
// video mode timing, bus and memory widths, register and state enums
package xv_pkg;

    // simulation video mode, counts in pixel clocks and lines
    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 2;
    localparam int H_BACK    = 4;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;    // 24 clocks per line
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 1;
    localparam int V_BACK    = 2;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;    // 12 lines per frame

    typedef logic [4:0]  hcount_t;
    typedef logic [3:0]  vcount_t;
    typedef logic [15:0] word_t;
    typedef logic [9:0]  addr_t;       // vram word address
    typedef logic [8:0]  xr_addr_t;    // bit 8 selects palette
    typedef logic [7:0]  color_t;      // palette index
    typedef logic [11:0] rgb_t;        // red in [11:8]
    typedef logic [1:0]  intr_t;

    localparam int INTR_VBLANK = 0;
    localparam int INTR_LINE   = 1;

    // counter compare points
    localparam hcount_t H_VIS_END  = hcount_t'(H_VISIBLE);
    localparam hcount_t H_SYNC_BEG = hcount_t'(H_VISIBLE + H_FRONT);
    localparam hcount_t H_SYNC_END = hcount_t'(H_VISIBLE + H_FRONT + H_SYNC);
    localparam hcount_t H_LAST     = hcount_t'(H_TOTAL - 1);
    localparam vcount_t V_VIS_END  = vcount_t'(V_VISIBLE);
    localparam vcount_t V_SYNC_BEG = vcount_t'(V_VISIBLE + V_FRONT);
    localparam vcount_t V_SYNC_END = vcount_t'(V_VISIBLE + V_FRONT + V_SYNC);
    localparam vcount_t V_LAST     = vcount_t'(V_TOTAL - 1);

    typedef enum logic [3:0] {
        REG_XM_ADDR    = 4'h0,
        REG_XM_DATA    = 4'h1,
        REG_XR_ADDR    = 4'h2,
        REG_XR_DATA    = 4'h3,
        REG_INT_CTRL   = 4'h4,
        REG_SYS_STATUS = 4'h5
    } reg_num_e;

    typedef enum logic [3:0] {
        VID_BASE      = 4'h0,
        VID_LINE_INTR = 4'h1
    } vid_reg_e;

    typedef enum logic [1:0] {ST_IDLE, ST_VRAM_WR, ST_VRAM_RD, ST_XR_WR} bus_state_e;

endpackage

//--- hw/xv_mem_bus_if.sv
// select/acknowledge memory bus
// requester holds sel and fields until the one-cycle ack
`timescale 1ns/1ps

interface xv_mem_bus_if;
    logic          sel;     // access request
    logic          ack;     // one cycle, read data valid here
    logic          wr;      // 1 = write
    xv_pkg::word_t addr;    // memory uses the low bits it needs
    xv_pkg::word_t wdata;
    xv_pkg::word_t rdata;

    modport requester (output sel, output wr, output addr, output wdata,
                       input ack, input rdata);

    modport memory (input sel, input wr, input addr, input wdata,
                     output ack, output rdata);
endinterface

//--- hw/xv_bus_regs.sv
// CPU register interface
// byte assembly, address auto-increment, vram prefetch, access sequencing
`timescale 1ns/1ps

module xv_bus_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_cs_n_i,     // strobe, one cycle low
    input  logic                bus_rd_nwr_i,
    input  logic [3:0]          bus_reg_num_i,
    input  logic                bus_bytesel_i,  // 0 = even (high) byte
    input  logic [7:0]          bus_data_i,
    output logic [7:0]          bus_data_o,
    xv_mem_bus_if.requester     vram_bus,
    xv_mem_bus_if.requester     xr_bus,
    input  logic                h_blank_i,
    input  logic                v_blank_i,
    input  xv_pkg::intr_t       intr_status_i,
    output xv_pkg::intr_t       intr_mask_o,
    output xv_pkg::intr_t       intr_clear_o    // one-cycle write-1 clear
);

    xv_pkg::bus_state_e state;
    xv_pkg::reg_num_e   reg_num;
    xv_pkg::addr_t      vram_addr;      // XM_ADDR
    xv_pkg::xr_addr_t   xr_addr;        // XR_ADDR
    xv_pkg::word_t      rd_buf;         // prefetched vram word
    xv_pkg::word_t      wr_data;        // word waiting for its access
    xv_pkg::word_t      bus_word;
    logic [7:0]         hi_byte;        // latched even byte
    logic               wr_strobe;
    logic               rd_strobe;
    logic               mem_busy;

    assign reg_num   = xv_pkg::reg_num_e'(bus_reg_num_i);
    assign wr_strobe = !bus_cs_n_i && !bus_rd_nwr_i;
    assign rd_strobe = !bus_cs_n_i && bus_rd_nwr_i;
    assign bus_word  = {hi_byte, bus_data_i};   // odd write commits
    assign mem_busy  = (state != xv_pkg::ST_IDLE);

    assign vram_bus.sel   = (state == xv_pkg::ST_VRAM_WR) || (state == xv_pkg::ST_VRAM_RD);
    assign vram_bus.wr    = (state == xv_pkg::ST_VRAM_WR);
    assign vram_bus.addr  = {6'b0, vram_addr};
    assign vram_bus.wdata = wr_data;
    assign xr_bus.sel     = (state == xv_pkg::ST_XR_WR);
    assign xr_bus.wr      = (state == xv_pkg::ST_XR_WR);    // XR is write-only
    assign xr_bus.addr    = {7'b0, xr_addr};
    assign xr_bus.wdata   = wr_data;

    // data path
    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            if (!bus_bytesel_i) begin
                hi_byte <= bus_data_i;
            end else if (reg_num == xv_pkg::REG_XM_DATA || reg_num == xv_pkg::REG_XR_DATA) begin
                wr_data <= bus_word;
            end
        end
        if (state == xv_pkg::ST_VRAM_RD && vram_bus.ack) begin
            rd_buf <= vram_bus.rdata;   // prefetch lands
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state        <= xv_pkg::ST_IDLE;
            vram_addr    <= '0;
            xr_addr      <= '0;
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
            bus_data_o   <= '0;
        end else begin
            intr_clear_o <= '0;     // strobe

            // finish pending access
            case (state)
                xv_pkg::ST_VRAM_WR: if (vram_bus.ack) begin
                    vram_addr <= vram_addr + 1'b1;  // auto-increment after write
                    state     <= xv_pkg::ST_IDLE;
                end
                xv_pkg::ST_VRAM_RD: if (vram_bus.ack) state <= xv_pkg::ST_IDLE;
                xv_pkg::ST_XR_WR: if (xr_bus.ack) begin
                    xr_addr <= xr_addr + 1'b1;
                    state   <= xv_pkg::ST_IDLE;
                end
                default: ;
            endcase

            if (wr_strobe && !bus_bytesel_i) begin
                if (reg_num == xv_pkg::REG_INT_CTRL) intr_mask_o <= bus_data_i[1:0];
            end else if (wr_strobe) begin
                case (reg_num)
                    xv_pkg::REG_XM_ADDR: begin
                        vram_addr <= bus_word[9:0];
                        state     <= xv_pkg::ST_VRAM_RD;    // prefetch new address
                    end
                    xv_pkg::REG_XM_DATA:  state        <= xv_pkg::ST_VRAM_WR;
                    xv_pkg::REG_XR_ADDR:  xr_addr      <= bus_word[8:0];
                    xv_pkg::REG_XR_DATA:  state        <= xv_pkg::ST_XR_WR;
                    xv_pkg::REG_INT_CTRL: intr_clear_o <= bus_data_i[1:0];
                    default: ;
                endcase
            end

            if (rd_strobe) begin
                case (reg_num)
                    xv_pkg::REG_XM_ADDR:
                        bus_data_o <= bus_bytesel_i ? vram_addr[7:0] : {6'b0, vram_addr[9:8]};
                    xv_pkg::REG_XM_DATA: begin
                        bus_data_o <= bus_bytesel_i ? rd_buf[7:0] : rd_buf[15:8];
                        if (bus_bytesel_i) begin    // odd byte ends the word
                            vram_addr <= vram_addr + 1'b1;
                            state     <= xv_pkg::ST_VRAM_RD;
                        end
                    end
                    xv_pkg::REG_INT_CTRL:
                        bus_data_o <= {6'b0, bus_bytesel_i ? intr_status_i : intr_mask_o};
                    xv_pkg::REG_SYS_STATUS:
                        bus_data_o <= bus_bytesel_i ? {5'b0, h_blank_i, v_blank_i, mem_busy} : 8'h00;
                    default: bus_data_o <= 8'h00;
                endcase
            end
        end
    end

endmodule

//--- hw/xv_vram_arb.sv
// vram array with video read port and CPU port
// video fetch has priority, CPU served in free cycles
`timescale 1ns/1ps

module xv_vram_arb (
    input  logic                clk,
    input  logic                vgen_sel_i,     // video fetch this cycle
    input  xv_pkg::addr_t       vgen_addr_i,
    output xv_pkg::word_t       vram_data_o,    // one cycle after select
    xv_mem_bus_if.memory        regs_bus
);

    xv_pkg::word_t mem [1024];  // 1024 x 16 video memory
    xv_pkg::word_t rd_word;     // single read register for both users
    xv_pkg::addr_t mem_addr;
    logic          cpu_go;      // CPU owns the port this cycle
    logic          ack_r;

    // ack cycle still has sel high, so do not serve it twice
    assign cpu_go   = regs_bus.sel && !vgen_sel_i && !ack_r;
    assign mem_addr = vgen_sel_i ? vgen_addr_i : regs_bus.addr[9:0];

    always_ff @(posedge clk) begin
        if (cpu_go && regs_bus.wr) begin
            mem[mem_addr] <= regs_bus.wdata;    // whole-word write
        end
        rd_word <= mem[mem_addr];
        ack_r   <= cpu_go;
    end

    assign vram_data_o    = rd_word;
    assign regs_bus.rdata = rd_word;    // valid with ack
    assign regs_bus.ack   = ack_r;

endmodule

//--- hw/xv_xr_mem.sv
// XR write decode and palette memory
// video register write strobe out, registered palette lookup for pixels
`timescale 1ns/1ps

module xv_xr_mem (
    input  logic                clk,
    xv_mem_bus_if.memory        xr_bus,
    output logic                vreg_wr_o,      // video register write strobe
    output xv_pkg::vid_reg_e    vreg_num_o,
    output xv_pkg::word_t       vreg_data_o,
    input  xv_pkg::color_t      color_index_i,
    output xv_pkg::rgb_t        color_rgb_o     // one cycle after index
);

    xv_pkg::rgb_t palette [256];
    logic         ack_r;
    logic         xr_wr;    // write accepted this cycle
    logic         pal_sel;  // addr bit 8

    assign xr_wr   = xr_bus.sel && xr_bus.wr && !ack_r;
    assign pal_sel = xr_bus.addr[8];

    always_ff @(posedge clk) begin
        ack_r <= xr_bus.sel && !ack_r;  // ack one cycle after sel

        // video registers live in the video generator
        vreg_wr_o   <= xr_wr && !pal_sel;
        vreg_num_o  <= xv_pkg::vid_reg_e'(xr_bus.addr[3:0]);
        vreg_data_o <= xr_bus.wdata;

        if (xr_wr && pal_sel) begin
            palette[xr_bus.addr[7:0]] <= xr_bus.wdata[11:0];    // 4:4:4 rgb
        end
        color_rgb_o <= palette[color_index_i];
    end

    assign xr_bus.ack   = ack_r;
    assign xr_bus.rdata = '0;   // no XR read path

endmodule

//--- hw/xv_video_gen.sv
// video timing, video registers, pixel fetch and output alignment
// also raises vblank and line-compare interrupt triggers
`timescale 1ns/1ps

module xv_video_gen (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                vreg_wr_i,
    input  xv_pkg::vid_reg_e    vreg_num_i,
    input  xv_pkg::word_t       vreg_data_i,
    output logic                vgen_sel_o,
    output xv_pkg::addr_t       vgen_addr_o,
    input  xv_pkg::word_t       vram_data_i,
    output xv_pkg::color_t      color_index_o,
    input  xv_pkg::rgb_t        color_rgb_i,
    output logic                h_blank_o,
    output logic                v_blank_o,
    output xv_pkg::intr_t       intr_trigger_o,
    output logic [3:0]          red_o,
    output logic [3:0]          green_o,
    output logic [3:0]          blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

    xv_pkg::hcount_t h_cnt;
    xv_pkg::vcount_t v_cnt;
    xv_pkg::addr_t   vid_base;      // VID_BASE
    xv_pkg::word_t   line_intr;     // VID_LINE_INTR
    logic            visible;
    logic            hsync;
    logic            vsync;
    logic [1:0]      de_pipe;       // stage 1 fetch, stage 2 palette
    logic [1:0]      hs_pipe;
    logic [1:0]      vs_pipe;
    logic            odd_d1;        // pixel phase when vram word arrives
    logic [7:0]      lo_byte;       // second pixel of the word

    assign h_blank_o = (h_cnt >= xv_pkg::H_VIS_END);
    assign v_blank_o = (v_cnt >= xv_pkg::V_VIS_END);
    assign visible   = !h_blank_o && !v_blank_o;
    assign hsync     = (h_cnt >= xv_pkg::H_SYNC_BEG) && (h_cnt < xv_pkg::H_SYNC_END);
    assign vsync     = (v_cnt >= xv_pkg::V_SYNC_BEG) && (v_cnt < xv_pkg::V_SYNC_END);

    // one word per pixel pair, line stride of 8 words
    assign vgen_sel_o    = visible && !h_cnt[0];
    assign vgen_addr_o   = vid_base + {4'b0, v_cnt[2:0], h_cnt[3:1]};
    assign color_index_o = odd_d1 ? lo_byte : vram_data_i[15:8];   // high byte first

    always_ff @(posedge clk) begin
        odd_d1 <= h_cnt[0];
        if (!odd_d1) lo_byte <= vram_data_i[7:0];   // hold past CPU slot
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt          <= '0;
            v_cnt          <= '0;
            vid_base       <= '0;
            line_intr      <= '1;   // matches no line until written
            intr_trigger_o <= '0;
            de_pipe        <= '0;
            hs_pipe        <= '0;
            vs_pipe        <= '0;
            {red_o, green_o, blue_o} <= '0;
            hsync_o        <= 1'b0;
            vsync_o        <= 1'b0;
            dv_de_o        <= 1'b0;
        end else begin
            if (h_cnt == xv_pkg::H_LAST) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == xv_pkg::V_LAST) ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end

            if (vreg_wr_i) begin
                case (vreg_num_i)
                    xv_pkg::VID_BASE:      vid_base  <= vreg_data_i[9:0];
                    xv_pkg::VID_LINE_INTR: line_intr <= vreg_data_i;
                    default: ;
                endcase
            end

            // pulses on first clock of the line
            intr_trigger_o[xv_pkg::INTR_VBLANK] <= (h_cnt == '0) && (v_cnt == xv_pkg::V_VIS_END);
            intr_trigger_o[xv_pkg::INTR_LINE]   <= (h_cnt == '0) && (line_intr == {12'b0, v_cnt});

            // align syncs and de with palette result, 3 clocks to pins
            de_pipe <= {de_pipe[0], visible};
            hs_pipe <= {hs_pipe[0], hsync};
            vs_pipe <= {vs_pipe[0], vsync};
            dv_de_o <= de_pipe[1];
            hsync_o <= hs_pipe[1];
            vsync_o <= vs_pipe[1];
            {red_o, green_o, blue_o} <= de_pipe[1] ? color_rgb_i : '0;  // black in blanking
        end
    end

endmodule

//--- hw/xv_intr_ctrl.sv
// interrupt controller
// sticky status, write-1 clear, masked bus pulse
`timescale 1ns/1ps

module xv_intr_ctrl (
    input  logic            clk,
    input  logic            reset_i,
    input  xv_pkg::intr_t   intr_trigger_i,     // one-cycle pulses
    input  xv_pkg::intr_t   intr_mask_i,
    input  xv_pkg::intr_t   intr_clear_i,
    output xv_pkg::intr_t   intr_status_o,
    output logic            bus_intr_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_status_o <= '0;
            bus_intr_o    <= 1'b0;
        end else begin
            // pulse only for enabled source not already pending
            bus_intr_o    <= |(intr_trigger_i & intr_mask_i & ~intr_status_o);
            // status records every trigger, mask or not
            intr_status_o <= (intr_status_o | intr_trigger_i) & ~intr_clear_i;
        end
    end

endmodule

//--- hw/xv_top.sv
// video controller top level
// CPU register bus in, 12-bit rgb with syncs out
`timescale 1ns/1ps

module xv_top (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,
    input  logic        bus_rd_nwr_i,       // 0 = write
    input  logic [3:0]  bus_reg_num_i,
    input  logic        bus_bytesel_i,
    input  logic [7:0]  bus_data_i,
    output logic [7:0]  bus_data_o,
    output logic        bus_intr_o,
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

    logic             vgen_sel;
    xv_pkg::addr_t    vgen_addr;
    xv_pkg::word_t    vram_rdata;
    xv_pkg::color_t   color_index;
    xv_pkg::rgb_t     color_rgb;
    logic             vreg_wr;
    xv_pkg::vid_reg_e vreg_num;
    xv_pkg::word_t    vreg_data;
    xv_pkg::intr_t    intr_trigger;
    xv_pkg::intr_t    intr_mask;
    xv_pkg::intr_t    intr_clear;
    xv_pkg::intr_t    intr_status;
    logic             h_blank;
    logic             v_blank;

    xv_mem_bus_if vram_bus ();  // regs to vram
    xv_mem_bus_if xr_bus ();    // regs to XR

    xv_bus_regs u_bus_regs (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .bus_data_o,
        .vram_bus(vram_bus.requester), .xr_bus(xr_bus.requester),
        .h_blank_i(h_blank), .v_blank_i(v_blank),
        .intr_status_i(intr_status), .intr_mask_o(intr_mask), .intr_clear_o(intr_clear)
    );

    xv_vram_arb u_vram_arb (
        .clk, .vgen_sel_i(vgen_sel), .vgen_addr_i(vgen_addr),
        .vram_data_o(vram_rdata), .regs_bus(vram_bus.memory)
    );

    xv_xr_mem u_xr_mem (
        .clk, .xr_bus(xr_bus.memory),
        .vreg_wr_o(vreg_wr), .vreg_num_o(vreg_num), .vreg_data_o(vreg_data),
        .color_index_i(color_index), .color_rgb_o(color_rgb)
    );

    xv_video_gen u_video_gen (
        .clk, .reset_i,
        .vreg_wr_i(vreg_wr), .vreg_num_i(vreg_num), .vreg_data_i(vreg_data),
        .vgen_sel_o(vgen_sel), .vgen_addr_o(vgen_addr), .vram_data_i(vram_rdata),
        .color_index_o(color_index), .color_rgb_i(color_rgb),
        .h_blank_o(h_blank), .v_blank_o(v_blank), .intr_trigger_o(intr_trigger),
        .red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .dv_de_o
    );

    xv_intr_ctrl u_intr_ctrl (
        .clk, .reset_i,
        .intr_trigger_i(intr_trigger), .intr_mask_i(intr_mask), .intr_clear_i(intr_clear),
        .intr_status_o(intr_status), .bus_intr_o
    );

endmodule

//--- bench/tb_clock.sv
// testbench clock source, 40 ns period
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 20;    // ns

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

//--- bench/tb_top.sv
// video controller testbench
// bus and compare tasks, xorshift stimulus, directed tests, watchdog
`timescale 1ns/1ps

module tb_top;

    localparam int CLK_PERIOD  = 40;
    localparam int FRAME_CLKS  = xv_pkg::H_TOTAL * xv_pkg::V_TOTAL;   // 288
    // ten frames of video plus bus traffic, 200 us
    localparam int WATCHDOG_NS = (10 * FRAME_CLKS + 2120) * CLK_PERIOD;

    logic               clk;
    logic               reset;
    logic               bus_cs_n;
    logic               bus_rd_nwr;
    logic [3:0]         bus_reg_num;
    logic               bus_bytesel;
    logic [7:0]         bus_din;
    logic [7:0]         bus_dout;
    logic               bus_intr;
    logic [3:0]         red;
    logic [3:0]         green;
    logic [3:0]         blue;
    logic               hsync;
    logic               vsync;
    logic               dv_de;
    logic [31:0]        rng_state;
    int                 err_cnt;
    xv_pkg::rgb_t       pal_model [256];    // palette as written
    xv_pkg::word_t      vram_model [64];    // words from VID_BASE on
    xv_pkg::rgb_t       captured [128];     // one visible frame

    tb_clock u_tb_clock (.clk);

    xv_top u_xv_top (
        .clk, .reset_i(reset),
        .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_reg_num_i(bus_reg_num),
        .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_din), .bus_data_o(bus_dout),
        .bus_intr_o(bus_intr), .red_o(red), .green_o(green), .blue_o(blue),
        .hsync_o(hsync), .vsync_o(vsync), .dv_de_o(dv_de)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_cnt++;
            stop_with_failure();
        end
    endtask

    task automatic check_rgb(input string name, input xv_pkg::rgb_t exp, input xv_pkg::rgb_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_cnt++;
            stop_with_failure();
        end
    endtask

    task automatic check_intr(input string name, input xv_pkg::intr_t exp,
                              input xv_pkg::intr_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            err_cnt++;
            stop_with_failure();
        end
    endtask

    // one strobe cycle, inputs change on falling edges
    task automatic bus_write(input xv_pkg::reg_num_e num, input logic odd, input logic [7:0] data);
        @(negedge clk);
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = 1'b0;
        bus_reg_num = num;
        bus_bytesel = odd;
        bus_din     = data;
        @(negedge clk);
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
    endtask

    task automatic bus_read(input xv_pkg::reg_num_e num, input logic odd, output logic [7:0] data);
        @(negedge clk);
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = num;
        bus_bytesel = odd;
        @(negedge clk);
        bus_cs_n    = 1'b1;
        data        = bus_dout;     // held until next strobe
    endtask

    task automatic write_word(input xv_pkg::reg_num_e num, input xv_pkg::word_t w);
        bus_write(num, 1'b0, w[15:8]);  // even byte latched
        bus_write(num, 1'b1, w[7:0]);   // odd byte commits
    endtask

    task automatic wait_idle();
        logic [7:0] status;
        int         polls;
        polls = 0;
        do begin
            bus_read(xv_pkg::REG_SYS_STATUS, 1'b1, status);
            polls++;
            if (polls >= 1000 && status[0]) begin
                $display("memory access still busy after 1000 status polls");
                stop_with_failure();
            end
        end while (status[0]);
    endtask

    // returns just after vsync rises
    task automatic wait_vsync();
        logic prev;
        prev = 1'b1;
        for (int n = 0; n < 2 * FRAME_CLKS; n++) begin
            @(negedge clk);
            if (vsync && !prev) return;
            prev = vsync;
        end
        $display("no vsync pulse within two frames");
        stop_with_failure();
    endtask

    task automatic capture_frame();
        int count;
        int n;
        count = 0;
        n     = 0;
        while (count < 128) begin
            @(negedge clk);
            if (dv_de) begin
                captured[count] = {red, green, blue};
                count++;
            end
            n++;
            if (n > 2 * FRAME_CLKS) begin
                $display("fewer than 128 visible pixels within two frames");
                stop_with_failure();
            end
        end
    endtask

    task automatic count_intr_pulses(input int clocks, output int pulses);
        pulses = 0;
        for (int n = 0; n < clocks; n++) begin
            @(negedge clk);
            if (bus_intr) pulses++;
        end
    endtask

    task automatic test_after_reset();
        logic [7:0] v;
        bus_read(xv_pkg::REG_INT_CTRL, 1'b0, v);
        check_byte("after_reset int_ctrl mask", 8'h00, v);
        bus_read(xv_pkg::REG_INT_CTRL, 1'b1, v);
        check_byte("after_reset int_ctrl status", 8'h00, v);
        bus_read(xv_pkg::REG_SYS_STATUS, 1'b1, v);
        check_byte("after_reset mem_busy", 8'h00, {7'b0, v[0]});
        check_byte("after_reset bus_intr", 8'h00, {7'b0, bus_intr});
    endtask

    task automatic test_vram_round_trip();
        xv_pkg::addr_t base;
        xv_pkg::word_t words [8];
        logic [7:0]    v;
        base = xv_pkg::addr_t'(next_rand());
        write_word(xv_pkg::REG_XM_ADDR, {6'b0, base});
        wait_idle();    // prefetch after address write
        for (int i = 0; i < 8; i++) begin
            words[i] = xv_pkg::word_t'(next_rand());
            write_word(xv_pkg::REG_XM_DATA, words[i]);
            wait_idle();
        end
        write_word(xv_pkg::REG_XM_ADDR, {6'b0, base});
        wait_idle();
        for (int i = 0; i < 8; i++) begin
            bus_read(xv_pkg::REG_XM_DATA, 1'b0, v);
            check_byte($sformatf("vram_round_trip word %0d high", i), words[i][15:8], v);
            bus_read(xv_pkg::REG_XM_DATA, 1'b1, v);     // steps address, new prefetch
            check_byte($sformatf("vram_round_trip word %0d low", i), words[i][7:0], v);
            wait_idle();
        end
    endtask

    task automatic test_picture();
        logic [7:0]    pal_hi;      // 16 palette entries in use
        xv_pkg::addr_t base;
        xv_pkg::rgb_t  rgb;
        xv_pkg::word_t w;
        logic [31:0]   r;
        logic [7:0]    idx;
        int            x;
        int            y;
        pal_hi = next_rand() & 32'hf0;
        write_word(xv_pkg::REG_XR_ADDR, {7'b0, 1'b1, pal_hi});  // bit 8 selects palette
        for (int i = 0; i < 16; i++) begin
            rgb = xv_pkg::rgb_t'(next_rand());
            pal_model[pal_hi + 8'(i)] = rgb;
            write_word(xv_pkg::REG_XR_DATA, {4'b0, rgb});
            wait_idle();
        end
        base = xv_pkg::addr_t'(next_rand());
        write_word(xv_pkg::REG_XR_ADDR, 16'(xv_pkg::VID_BASE));
        write_word(xv_pkg::REG_XR_DATA, {6'b0, base});
        wait_idle();
        write_word(xv_pkg::REG_XM_ADDR, {6'b0, base});
        wait_idle();
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            w = {pal_hi | {4'b0, r[3:0]}, pal_hi | {4'b0, r[7:4]}};
            vram_model[i] = w;
            write_word(xv_pkg::REG_XM_DATA, w);
            wait_idle();
        end
        wait_vsync();
        capture_frame();
        for (int p = 0; p < 128; p++) begin
            y   = p / 16;
            x   = p % 16;
            w   = vram_model[y * 8 + x / 2];
            idx = (x % 2 == 1) ? w[7:0] : w[15:8];  // high byte is left pixel
            check_rgb($sformatf("picture pixel x %0d y %0d", x, y), pal_model[idx], captured[p]);
        end
    endtask

    task automatic test_frame_shape();
        int   runs;
        int   run_len;
        logic prev_de;
        int   hs_runs;
        int   hs_len;
        logic prev_hs;
        int   vs_clks;
        runs    = 0;
        run_len = 0;
        prev_de = 1'b0;
        hs_runs = 0;
        hs_len  = 0;
        prev_hs = 1'b0;
        vs_clks = 0;
        wait_vsync();
        for (int n = 0; n < FRAME_CLKS; n++) begin
            @(negedge clk);
            if (dv_de) begin
                run_len++;
            end else begin
                check_rgb("frame_shape rgb in blanking", '0, {red, green, blue});
                if (prev_de) begin  // run just ended
                    runs++;
                    check_byte("frame_shape run length", 8'd16, 8'(run_len));
                end
                run_len = 0;
            end
            prev_de = dv_de;
            if (hsync) begin
                hs_len++;
            end else begin
                if (prev_hs) begin  // one sync pulse per line
                    hs_runs++;
                    check_byte("frame_shape hsync length", 8'd2, 8'(hs_len));
                end
                hs_len = 0;
            end
            prev_hs = hsync;
            if (vsync) vs_clks++;   // one full line of vsync
        end
        check_byte("frame_shape run count", 8'd8, 8'(runs));
        check_byte("frame_shape hsync count", 8'd12, 8'(hs_runs));
        check_byte("frame_shape vsync clocks", 8'd24, 8'(vs_clks));
    endtask

    task automatic test_interrupts();
        logic [7:0] v;
        int         pulses;
        write_word(xv_pkg::REG_XR_ADDR, 16'(xv_pkg::VID_LINE_INTR));
        write_word(xv_pkg::REG_XR_DATA, 16'd3);
        wait_idle();
        bus_write(xv_pkg::REG_INT_CTRL, 1'b0, 8'h01);   // vblank only
        // clear well away from line 3 and line 8 triggers
        wait_vsync();
        bus_write(xv_pkg::REG_INT_CTRL, 1'b1, 8'h03);
        pulses = 0;
        for (int n = 0; n < FRAME_CLKS + 48 && pulses == 0; n++) begin
            @(negedge clk);
            if (bus_intr) pulses = 1;
        end
        if (pulses == 0) begin
            $display("no interrupt pulse within one frame with vblank unmasked");
            stop_with_failure();
        end
        bus_read(xv_pkg::REG_INT_CTRL, 1'b1, v);
        check_intr("interrupts status after pulse", 2'b11, v[1:0]);
        bus_write(xv_pkg::REG_INT_CTRL, 1'b1, 8'h03);
        bus_read(xv_pkg::REG_INT_CTRL, 1'b1, v);
        check_intr("interrupts status after clear", 2'b00, v[1:0]);
        bus_write(xv_pkg::REG_INT_CTRL, 1'b0, 8'h00);   // all masked
        count_intr_pulses(FRAME_CLKS + 24, pulses);
        check_byte("interrupts pulses while masked", 8'd0, 8'(pulses));
        bus_read(xv_pkg::REG_INT_CTRL, 1'b1, v);
        check_intr("interrupts status while masked", 2'b11, v[1:0]);
    endtask

    // watchdog
    initial begin
        #WATCHDOG_NS;
        $display("watchdog timeout, tests did not finish in time");
        stop_with_failure();
    end

    initial begin
        rng_state   = 32'd53;
        err_cnt     = 0;
        reset       = 1'b1;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = 4'h0;
        bus_bytesel = 1'b0;
        bus_din     = 8'h00;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_after_reset();
        test_vram_round_trip();
        test_picture();
        test_frame_shape();
        test_interrupts();

        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

//--- sim.f
hw/xv_pkg.sv
hw/xv_mem_bus_if.sv
hw/xv_bus_regs.sv
hw/xv_vram_arb.sv
hw/xv_xr_mem.sv
hw/xv_video_gen.sv
hw/xv_intr_ctrl.sv
hw/xv_top.sv
bench/tb_clock.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_top --Mdir obj_dir -o tb_top_sim
out=$(./obj_dir/tb_top_sim || true)
echo "$out"
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
